// File: Bender.yml
package:
  name: fp_unit

sources:
  - include_dirs:
      - common
    files:
      - common/fp_pkg.sv
      - hw/fp_compare.sv
      - hw/fp_adder.sv
      - hw/fp_multiplier.sv
      - fp_divider/fp_recip_datapath.sv
      - fp_divider/fp_divider.sv
      - hw/fp_unit.sv
  - target: test
    include_dirs:
      - common
      - dv
    files:
      - dv/fp_unit_tb.sv

// File: common/fp_defs.svh
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// exponent field limits
`define FP_BIAS        8'd127
`define FP_EXP_MAX     8'hFF

// handy constant words
`define FP_ONE         32'h3F80_0000    // 1.0
`define FP_TWO         32'h4000_0000    // 2.0

// linear reciprocal seed x0 = 48/17 - 32/17 * d, d in [0.5, 1)
`define FP_SEED_SCALE  32'h3FF0_F0F1    // 32/17
`define FP_SEED_OFFSET 32'h4034_B4B5    // 48/17
`define FP_SCALED_EXP  8'd126           // puts 1.f into [0.5, 1)

// newton steps per division
`define FP_DIV_ITER    4

`endif

// File: common/fp_pkg.sv
`default_nettype none

package fp_pkg;

    typedef logic [31:0] fp32_t;    // sign, exponent, fraction
    typedef logic [7:0]  fp_exp_t;  // biased exponent
    typedef logic [22:0] fp_frac_t; // stored fraction
    typedef logic [23:0] fp_mant_t; // fraction with hidden one

    // operation codes of a request
    typedef enum logic [1:0] {
        FP_ADD = 2'd0,
        FP_MUL = 2'd1,
        FP_DIV = 2'd2,
        FP_CMP = 2'd3
    } fp_op_e;

    // divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE   = 2'd0,
        DIV_SEED   = 2'd1,
        DIV_REFINE = 2'd2,
        DIV_FINISH = 2'd3
    } div_state_e;

    // one request as handed in with start
    typedef struct packed {
        fp_op_e op;
        fp32_t  a;
        fp32_t  b;
    } fp_req_t;

endpackage

`default_nettype wire

// File: dv/fp_model.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// reference arithmetic for the fp_unit checks
// truncating with a hidden one always present and no inf or nan handling

// signed greater-than as returned in bit 0 of a cmp result
function automatic logic model_greater(input fp_pkg::fp32_t a, input fp_pkg::fp32_t b);
    logic field_gt;
    if (a[31] != b[31]) return ~a[31];     // positive side wins
    field_gt = (a[30:0] > b[30:0]);        // exponent sits above fraction so one compare covers both
    return field_gt ^ a[31];               // order flips for negatives
endfunction

function automatic fp_pkg::fp32_t model_add(input fp_pkg::fp32_t a, input fp_pkg::fp32_t b);
    fp_pkg::fp32_t big, little;
    int            shift;
    int            exp_r;
    int            steps;
    logic [23:0]   m_small;
    logic [24:0]   m;                      // one spare bit for the carry
    if (a[30:0] > b[30:0]) begin
        big    = a;
        little = b;
    end else begin
        big    = b;                        // ties go to b
        little = a;
    end
    shift   = int'(big[30:23]) - int'(little[30:23]);
    m_small = (shift > 23) ? 24'd0 : ({1'b1, little[22:0]} >> shift);
    if (big[31] == little[31]) m = {1'b1, big[22:0]} + m_small;
    else                       m = {1'b1, big[22:0]} - m_small;
    exp_r = int'(big[30:23]);
    if (m[24]) begin
        m     = m >> 1;
        exp_r = (exp_r < 255) ? exp_r + 1 : 255;   // saturate
    end else if (m != 25'd0) begin
        steps = 0;
        while (!m[23] && exp_r > 0 && steps < 24) begin
            m     = m << 1;
            exp_r = exp_r - 1;
            steps = steps + 1;
        end
    end
    return {big[31], exp_r[7:0], m[22:0]};
endfunction

function automatic fp_pkg::fp32_t model_mul(input fp_pkg::fp32_t a, input fp_pkg::fp32_t b);
    logic [47:0]      p;
    int               e;
    fp_pkg::fp_frac_t f;
    logic             s;
    s = a[31] ^ b[31];
    p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - int'(`FP_BIAS);
    if (p[47]) begin
        f = p[46:24];
        e = e + 1;
    end else begin
        f = p[45:23];
    end
    if (e >= 255) return {s, `FP_EXP_MAX, 23'd0};
    if (e <= 0)   return {s, 31'd0};            // sign survives the flush
    return {s, e[7:0], f};
endfunction

// newton-raphson quotient with iter refinement steps
function automatic fp_pkg::fp32_t model_div(input fp_pkg::fp32_t a, input fp_pkg::fp32_t b,
                                            input int iter);
    fp_pkg::fp32_t d, x, dx, corr, recip;
    logic [7:0]    rexp;
    d  = {1'b0, `FP_SCALED_EXP, b[22:0]};
    dx = model_mul(d, `FP_SEED_SCALE);
    x  = model_add(`FP_SEED_OFFSET, {~dx[31], dx[30:0]});
    for (int i = 0; i < iter; i++) begin
        dx   = model_mul(d, x);
        corr = model_add(`FP_TWO, {~dx[31], dx[30:0]});
        x    = model_mul(x, corr);
    end
    rexp  = x[30:23] + `FP_SCALED_EXP - b[30:23];   // wraps in 8 bits
    recip = {b[31], rexp, x[22:0]};
    return model_mul(a, recip);
endfunction

`endif

// File: dv/fp_unit_tb.sv
`default_nettype none

`include "fp_defs.svh"

module fp_unit_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int N_ADD        = 200;
    localparam int N_MUL        = 200;
    localparam int N_CLAMP      = 20;   // per clamp direction
    localparam int N_CMP        = 200;
    localparam int N_CMP_EXTRA  = 20;   // per corner case
    localparam int N_DIV        = 100;
    localparam int N_BUSY       = 4;
    localparam int N_REQUESTS   = N_ADD + N_MUL + 2 * N_CLAMP + N_CMP + 2 * N_CMP_EXTRA
                                + N_DIV + N_BUSY;
    localparam int DONE_LIMIT   = `FP_DIV_ITER + 20;   // give up on one request after this
    localparam longint WATCHDOG_TIME =
        (longint'(N_REQUESTS) * (`FP_DIV_ITER + 10) + RESET_CYCLES) * CLK_PERIOD;

    logic            clock;
    logic            rst_n;
    fp_pkg::fp_req_t req;
    logic            start;
    fp_pkg::fp32_t   result;
    logic            done;
    logic            busy;

    logic [31:0] rng_state   = 32'd61;
    int          error_count = 0;
    int          check_count = 0;

`include "fp_model.svh"

    fp_unit dut_i (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (req),
        .start  (start),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // random word, exponent somewhere in lo..hi
    function automatic fp_pkg::fp32_t random_operand(input int lo, input int hi);
        logic [31:0]     r;
        logic [31:0]     span;
        fp_pkg::fp_exp_t e;
        r    = next_random();
        span = next_random() % (hi - lo + 1);
        e    = 8'(lo + span);
        return {r[31], e, r[22:0]};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_outputs_idle(input string name);
        check({name, " done"}, 0, done);
        check({name, " busy"}, 0, busy);
        check({name, " result"}, 0, result);
    endtask

    // one request, called just after a rising edge; returns result and cycles to done
    task automatic run_request(input fp_pkg::fp_op_e op, input fp_pkg::fp32_t a,
                               input fp_pkg::fp32_t b, output fp_pkg::fp32_t res,
                               output int cycles);
        req.op = op;
        req.a  = a;
        req.b  = b;
        start  = 1'b1;
        @(posedge clock);
        #1;
        start  = 1'b0;
        cycles = 1;
        while (!done && cycles < DONE_LIMIT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!done) begin
            error_count++;
            $display("request with op %0d got no done within %0d cycles", op, DONE_LIMIT);
        end
        res = result;
    endtask

    task automatic test_add();
        fp_pkg::fp32_t a, b, res;
        int            cycles;
        for (int i = 0; i < N_ADD; i++) begin
            a = random_operand(1, 254);
            b = random_operand(1, 254);
            if (i % 5 == 0) b = {~a[31], a[30:0]};   // exact cancellation
            run_request(fp_pkg::FP_ADD, a, b, res, cycles);
            check("add", model_add(a, b), res);
            check("add latency", 2, cycles);
        end
    endtask

    task automatic test_mul();
        fp_pkg::fp32_t a, b, res;
        int            cycles;
        for (int i = 0; i < N_MUL; i++) begin
            a = random_operand(1, 254);
            b = random_operand(1, 254);
            run_request(fp_pkg::FP_MUL, a, b, res, cycles);
            check("mul", model_mul(a, b), res);
        end
        for (int i = 0; i < N_CLAMP; i++) begin
            a = random_operand(200, 254);   // sum far above 255
            b = random_operand(200, 254);
            run_request(fp_pkg::FP_MUL, a, b, res, cycles);
            check("mul overflow", model_mul(a, b), res);
            a = random_operand(1, 60);      // sum below the bias
            b = random_operand(1, 60);
            run_request(fp_pkg::FP_MUL, a, b, res, cycles);
            check("mul underflow", model_mul(a, b), res);
        end
    endtask

    task automatic test_cmp();
        fp_pkg::fp32_t a, b, res;
        int            cycles;
        for (int i = 0; i < N_CMP + 2 * N_CMP_EXTRA; i++) begin
            a = random_operand(1, 254);
            b = random_operand(1, 254);
            if (i >= N_CMP + N_CMP_EXTRA) b[31] = ~a[31];
            else if (i >= N_CMP)          b = a;
            run_request(fp_pkg::FP_CMP, a, b, res, cycles);
            check("cmp", {31'd0, model_greater(a, b)}, res);   // upper bits stay zero
        end
    endtask

    task automatic test_div();
        fp_pkg::fp32_t a, b, res;
        int            cycles;
        for (int i = 0; i < N_DIV; i++) begin
            a = random_operand(1, 254);
            b = random_operand(1, 254);
            run_request(fp_pkg::FP_DIV, a, b, res, cycles);
            check("div", model_div(a, b, `FP_DIV_ITER), res);
            check("div latency", `FP_DIV_ITER + 4, cycles);
        end
    endtask

    // a start during a division must be dropped
    task automatic test_busy();
        fp_pkg::fp32_t a1, b1, a2, b2, held;
        int            cycles;
        int            extra_done;
        a1 = random_operand(1, 254);
        b1 = random_operand(1, 254);
        a2 = random_operand(1, 254);
        b2 = random_operand(1, 254);
        req.op = fp_pkg::FP_DIV;
        req.a  = a1;
        req.b  = b1;
        start  = 1'b1;
        @(posedge clock);
        #1;
        start  = 1'b0;
        cycles = 1;
        check("busy level", 1, busy);
        req.a = a2;                          // second request while busy
        req.b = b2;
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
        cycles++;
        while (!done && cycles < DONE_LIMIT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        check("busy div", model_div(a1, b1, `FP_DIV_ITER), result);
        check("busy div latency", `FP_DIV_ITER + 4, cycles);
        held       = result;
        extra_done = 0;
        repeat (`FP_DIV_ITER + 6) begin
            @(posedge clock);
            #1;
            if (done) extra_done++;
            check("busy hold", held, result);
        end
        check("busy extra done", 0, extra_done);
        req.op = fp_pkg::FP_ADD;
        start  = 1'b1;
        @(posedge clock);
        #1;
        start  = 1'b0;
        cycles = 1;
        while (!done && cycles < DONE_LIMIT) begin
            check("busy hold", held, result);  // old value until the new done
            @(posedge clock);
            #1;
            cycles++;
        end
        check("busy next add", model_add(a2, b2), result);
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clock);
            #1;
            check_outputs_idle("reset");
        end
        rst_n = 1'b1;
        @(posedge clock);
        #1;
        check_outputs_idle("after reset");
        test_add();
        test_mul();
        test_cmp();
        test_div();
        test_busy();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // hard stop if a request never completes
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at time %0t, the tests did not finish", $time);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: fp_divider/fp_divider.sv
`default_nettype none

`include "fp_defs.svh"

// newton-raphson divider
// idle -> seed (1) -> refine (ITER) -> finish (1), quot_valid after finish
module fp_divider #(
    parameter int ITER = `FP_DIV_ITER
) (
    input  wire logic          clock,
    input  wire logic          rst_n,
    input  wire logic          start,
    input  wire fp_pkg::fp32_t a,
    input  wire fp_pkg::fp32_t b,
    output fp_pkg::fp32_t      quotient,
    output logic               quot_valid
);

    localparam int CNT_W = (ITER > 1) ? $clog2(ITER) : 1;

    fp_pkg::div_state_e state;
    logic [CNT_W-1:0]   iter_cnt;   // refinement steps done
    fp_pkg::fp32_t      a_q, b_q;   // operands held for the whole run
    fp_pkg::fp32_t      x_q;        // current reciprocal estimate
    fp_pkg::fp32_t      seed, x_next, quot_next;

    fp_recip_datapath u_datapath (
        .a        (a_q),
        .b        (b_q),
        .x        (x_q),
        .seed     (seed),
        .x_next   (x_next),
        .quotient (quot_next)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= fp_pkg::DIV_IDLE;
            iter_cnt   <= '0;
            quot_valid <= 1'b0;
        end else begin
            quot_valid <= 1'b0; // single cycle pulse
            case (state)
                fp_pkg::DIV_IDLE: begin
                    if (start) state <= fp_pkg::DIV_SEED; // start only heard here
                end
                fp_pkg::DIV_SEED: begin
                    iter_cnt <= '0;
                    state    <= fp_pkg::DIV_REFINE;
                end
                fp_pkg::DIV_REFINE: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (iter_cnt == CNT_W'(ITER - 1)) state <= fp_pkg::DIV_FINISH;
                end
                fp_pkg::DIV_FINISH: begin
                    quot_valid <= 1'b1;
                    state      <= fp_pkg::DIV_IDLE;
                end
                default: state <= fp_pkg::DIV_IDLE;
            endcase
        end
    end

    // operand, estimate and quotient registers
    always_ff @(posedge clock) begin
        if ((state == fp_pkg::DIV_IDLE) && start) begin
            a_q <= a;
            b_q <= b;
        end
        if (state == fp_pkg::DIV_SEED)   x_q      <= seed;
        if (state == fp_pkg::DIV_REFINE) x_q      <= x_next;
        if (state == fp_pkg::DIV_FINISH) quotient <= quot_next; // uses the refined x
    end

endmodule

`default_nettype wire

// File: fp_divider/fp_recip_datapath.sv
`default_nettype none

`include "fp_defs.svh"

// divider arithmetic, all combinational
//   seed     = 48/17 - 32/17 * d
//   x_next   = x * (2 - d * x)
//   quotient = a * x with b's exponent put back
module fp_recip_datapath (
    input  wire fp_pkg::fp32_t a,
    input  wire fp_pkg::fp32_t b,
    input  wire fp_pkg::fp32_t x,
    output fp_pkg::fp32_t      seed,
    output fp_pkg::fp32_t      x_next,
    output fp_pkg::fp32_t      quotient
);

    fp_pkg::fp32_t   d;          // divisor scaled into [0.5, 1), positive
    fp_pkg::fp32_t   d_scaled;   // d * 32/17
    fp_pkg::fp32_t   dx;         // d * x
    fp_pkg::fp32_t   corr;       // 2 - d * x
    fp_pkg::fp32_t   recip;      // x rescaled to 1/b
    fp_pkg::fp_exp_t recip_exp;

    assign d = {1'b0, `FP_SCALED_EXP, b[22:0]};

    // linear first guess
    fp_multiplier u_seed_mul (.a(d), .b(`FP_SEED_SCALE), .product(d_scaled));

    fp_adder u_seed_add (
        .a   (`FP_SEED_OFFSET),
        .b   ({1'b1, d_scaled[30:0]}),  // subtract via forced sign
        .sum (seed)
    );

    // one newton step
    fp_multiplier u_dx_mul (.a(d), .b(x), .product(dx));

    fp_adder u_corr_add (
        .a   (`FP_TWO),
        .b   ({~dx[31], dx[30:0]}),
        .sum (corr)
    );

    fp_multiplier u_step_mul (.a(x), .b(corr), .product(x_next));

    // undo the scaling, 8 bit wrap like the exponent field
    assign recip_exp = x[30:23] + `FP_SCALED_EXP - b[30:23];
    assign recip     = {b[31], recip_exp, x[22:0]};

    fp_multiplier u_quot_mul (.a(a), .b(recip), .product(quotient));

endmodule

`default_nettype wire

// File: fp_unit.f
+incdir+common
+incdir+dv
common/fp_pkg.sv
hw/fp_compare.sv
hw/fp_adder.sv
hw/fp_multiplier.sv
fp_divider/fp_recip_datapath.sv
fp_divider/fp_divider.sv
hw/fp_unit.sv
dv/fp_unit_tb.sv

// File: hw/fp_adder.sv
`default_nettype none

`include "fp_defs.svh"

// combinational add, subtract when signs differ
// truncating, hidden one always assumed
module fp_adder (
    input  wire fp_pkg::fp32_t a,
    input  wire fp_pkg::fp32_t b,
    output fp_pkg::fp32_t      sum
);

    logic             a_larger;          // |a| > |b|
    fp_pkg::fp32_t    larger, smaller;   // operands after magnitude swap
    logic             same_sign;
    fp_pkg::fp_exp_t  exp_diff;
    fp_pkg::fp_exp_t  exp_res;
    fp_pkg::fp_mant_t mant_big;
    fp_pkg::fp_mant_t mant_small;        // aligned to larger's exponent
    fp_pkg::fp_mant_t mant_res;
    logic             carry;

    // magnitude order, sign bits cleared
    fp_compare u_mag_cmp (
        .a         ({1'b0, a[30:0]}),
        .b         ({1'b0, b[30:0]}),
        .a_greater (a_larger)
    );

    assign larger    = a_larger ? a : b; // equal magnitudes pick b
    assign smaller   = a_larger ? b : a;
    assign same_sign = (larger[31] == smaller[31]);

    // exponent gap is never negative after the swap
    assign exp_diff   = larger[30:23] - smaller[30:23];
    assign mant_big   = {1'b1, larger[22:0]};
    assign mant_small = {1'b1, smaller[22:0]} >> exp_diff;

    always_comb begin
        // 25 bit sum keeps the carry
        if (same_sign) begin
            {carry, mant_res} = {1'b0, mant_big} + {1'b0, mant_small};
        end else begin
            {carry, mant_res} = {1'b0, mant_big} - {1'b0, mant_small}; // no borrow, big >= small
        end

        exp_res = larger[30:23];

        if (carry) begin
            // 1x.xxx, bring the carry back in as the hidden bit
            mant_res = {1'b1, mant_res[23:1]};
            exp_res  = (exp_res == `FP_EXP_MAX) ? `FP_EXP_MAX : exp_res + 8'd1;
        end else if (mant_res != '0) begin
            // cancellation, walk the leading one up to bit 23
            // exponent stops at 0 so it never underflows
            for (int i = 0; i < 24; i++) begin
                if (!mant_res[23] && (exp_res != 8'd0)) begin
                    mant_res = mant_res << 1;
                    exp_res  = exp_res - 8'd1;
                end
            end
        end
        // zero sum falls through: fraction 0, larger's exponent

        sum = {larger[31], exp_res, mant_res[22:0]}; // sign of the larger magnitude
    end

endmodule

`default_nettype wire

// File: hw/fp_compare.sv
`default_nettype none

// signed greater-than on two single-precision words
module fp_compare (
    input  wire fp_pkg::fp32_t a,
    input  wire fp_pkg::fp32_t b,
    output logic               a_greater
);

    fp_pkg::fp_exp_t  exp_a, exp_b;
    fp_pkg::fp_frac_t frac_a, frac_b;
    logic             field_greater; // a's magnitude field above b's

    assign exp_a  = a[30:23];
    assign exp_b  = b[30:23];
    assign frac_a = a[22:0];
    assign frac_b = b[22:0];

    always_comb begin
        // exponent decides first, fraction only on a tie
        if (exp_a != exp_b) begin
            field_greater = (exp_a > exp_b);
        end else begin
            field_greater = (frac_a > frac_b);
        end

        if (a[31] != b[31]) begin
            a_greater = ~a[31];              // the positive one wins
        end else begin
            a_greater = field_greater ^ a[31]; // negatives flip the order
        end
    end

endmodule

`default_nettype wire

// File: hw/fp_multiplier.sv
`default_nettype none

`include "fp_defs.svh"

// combinational multiply, truncating
// exponent clamps to 0 or all ones, no inf/nan handling
module fp_multiplier (
    input  wire fp_pkg::fp32_t a,
    input  wire fp_pkg::fp32_t b,
    output fp_pkg::fp32_t      product
);

    fp_pkg::fp_mant_t  mant_a, mant_b;
    logic [47:0]       prod;          // full 24x24 product
    logic signed [9:0] exp_sum;       // room for -127 .. 384
    fp_pkg::fp_frac_t  frac_res;
    logic              sign_res;

    assign mant_a   = {1'b1, a[22:0]};
    assign mant_b   = {1'b1, b[22:0]};
    assign prod     = mant_a * mant_b;
    assign sign_res = a[31] ^ b[31];

    always_comb begin
        // product of two 1.f values is in [1, 4)
        if (prod[47]) begin
            frac_res = prod[46:24];   // 1x.f, one more on the exponent
        end else begin
            frac_res = prod[45:23];
        end

        // unsigned 10 bit arithmetic, pattern is the signed result
        exp_sum = {2'b00, a[30:23]} + {2'b00, b[30:23]} - {2'b00, `FP_BIAS}
                + {9'd0, prod[47]};

        if (exp_sum >= 10'sd255) begin
            product = {sign_res, `FP_EXP_MAX, 23'd0}; // overflow clamp
        end else if (exp_sum <= 10'sd0) begin
            product = {sign_res, 8'd0, 23'd0};        // underflow to zero, sign kept
        end else begin
            product = {sign_res, exp_sum[7:0], frac_res};
        end
    end

endmodule

`default_nettype wire

// File: hw/fp_unit.sv
`default_nettype none

`include "fp_defs.svh"

// single-request floating-point unit
// add/mul/cmp: done one cycle after the request is taken
// div: done one cycle after the divider's quot_valid
module fp_unit (
    input  wire logic            clock,
    input  wire logic            rst_n,
    input  wire fp_pkg::fp_req_t req,
    input  wire logic            start,
    output fp_pkg::fp32_t        result,
    output logic                 done,
    output logic                 busy
);

    fp_pkg::fp_req_t req_q;       // accepted request
    logic            accept;
    logic            div_start;
    logic            finish;      // result ready this cycle
    logic            a_greater;
    logic            quot_valid;
    fp_pkg::fp32_t   sum, product, quotient;
    fp_pkg::fp32_t   result_next;

    assign accept    = start & ~busy;                     // start while busy is dropped
    assign div_start = accept & (req.op == fp_pkg::FP_DIV); // divider takes the raw request

    fp_compare u_compare (.a(req_q.a), .b(req_q.b), .a_greater(a_greater));

    fp_adder u_adder (.a(req_q.a), .b(req_q.b), .sum(sum));

    fp_multiplier u_multiplier (.a(req_q.a), .b(req_q.b), .product(product));

    fp_divider #(
        .ITER (`FP_DIV_ITER)
    ) u_divider (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (div_start),
        .a          (req.a),
        .b          (req.b),
        .quotient   (quotient),
        .quot_valid (quot_valid)
    );

    always_comb begin
        case (req_q.op)
            fp_pkg::FP_ADD: result_next = sum;
            fp_pkg::FP_MUL: result_next = product;
            fp_pkg::FP_CMP: result_next = {31'd0, a_greater}; // flag in bit 0
            default:        result_next = quotient;
        endcase
    end

    // combinational ops finish right away, div waits for the divider
    assign finish = busy & ((req_q.op != fp_pkg::FP_DIV) | quot_valid);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= finish;
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy   <= 1'b0;
                result <= result_next; // holds until the next done
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) req_q <= req;
    end

endmodule

`default_nettype wire
